// File: rtl/fpu_cfg.svh
// --------------------------------------------------
// fpu configuration
// register count, canonical nan and op-fp encodings
// --------------------------------------------------
`ifndef FPU_CFG_SVH
`define FPU_CFG_SVH

`define FPU_NUM_REGS   32
`define FPU_CANON_NAN  32'h7fc00000   // quiet nan, positive, payload zero

// opcode of all op-fp words
`define FPU_OPC_OPFP   7'b1010011

// funct7 groups, funct3 picks the variant
`define FPU_F7_SGNJ    7'b0010000
`define FPU_F7_MINMAX  7'b0010100
`define FPU_F7_CMP     7'b1010000
`define FPU_F7_MVXW    7'b1110000     // fp reg -> int reg
`define FPU_F7_MVWX    7'b1111000     // int reg -> fp reg

`endif

// File: rtl/fpu_pkg.sv
// --------------------------------------------------
// fpu package
// operation codes and the single precision word
// --------------------------------------------------
package fpu_pkg;

  // one code per supported op-fp instruction
  typedef enum logic [3:0] {
    FSGNJ,
    FSGNJN,
    FSGNJX,
    FMIN,
    FMAX,
    FEQ,
    FLT,
    FLE,
    MVXW,    // result goes to int side
    MVWX     // operand a is the int value
  } fp_op_e;

  // same 32 bits, either raw or split into ieee fields
  typedef union packed {
    logic [31:0] bits;
    struct packed {
      logic        sign;
      logic [7:0]  exponent;
      logic [22:0] mantissa;
    } fields;
  } fp32_word_u;

endpackage

// File: rtl/fpu_reg_file.sv
// --------------------------------------------------
// fp register file
// 32 single precision regs plus busy scoreboard,
// two async read ports, one write port
// --------------------------------------------------
`include "fpu_cfg.svh"

module fpu_reg_file (
  input  logic        frf_rf,
  input  logic        rst_n,
  input  logic [4:0]  rs1_addr,
  input  logic [4:0]  rs2_addr,
  input  logic [4:0]  rd_addr,
  input  logic        mark_en,   // set busy at issue
  input  logic [4:0]  mark_rd,
  input  logic        wen,       // writeback, clears busy
  input  logic [4:0]  wrd,
  input  logic [31:0] wdata,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data,
  output logic        rs1_busy,
  output logic        rs2_busy,
  output logic        rd_busy
);

  logic [`FPU_NUM_REGS-1:0][31:0] regs;
  logic [`FPU_NUM_REGS-1:0]       busy;   // one bit per reg, set = result pending

  always_ff @(posedge frf_rf or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `FPU_NUM_REGS; i++) begin
        regs[i] <= `FPU_CANON_NAN;   // every reg starts as qnan
      end
      busy <= '0;
    end else begin
      if (wen) begin
        regs[wrd] <= wdata;
        busy[wrd] <= 1'b0;
      end
      // later assignment, so a new mark beats a retiring write
      if (mark_en) begin
        busy[mark_rd] <= 1'b1;
      end
    end
  end

  // reads see the old value during a write edge
  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

  assign rs1_busy = busy[rs1_addr];
  assign rs2_busy = busy[rs2_addr];
  assign rd_busy  = busy[rd_addr];   // waw check for fp destinations

  // every writeback must retire something decode marked earlier
  a_wr_busy : assert property (@(posedge frf_rf) disable iff (!rst_n)
    wen |-> busy[wrd])
    else $error("writeback to reg %0d with busy bit clear", wrd);

endmodule

// File: rtl/fpu_decode.sv
// --------------------------------------------------
// fpu decode
// splits the op-fp word, checks the scoreboard,
// stalls or issues operands to execute
// --------------------------------------------------
`include "fpu_cfg.svh"

module fpu_decode import fpu_pkg::*; (
  input  logic        frf_rf,
  input  logic        rst_n,
  input  logic        instr_valid,
  input  logic [31:0] instr,
  input  logic [31:0] int_operand,  // int rs1 for fmv.w.x
  input  logic [31:0] rs1_data,
  input  logic [31:0] rs2_data,
  input  logic        rs1_busy,
  input  logic        rs2_busy,
  input  logic        rd_busy,
  output logic [4:0]  rs1_addr,
  output logic [4:0]  rs2_addr,
  output logic [4:0]  rd_addr,
  output logic        mark_en,
  output logic [4:0]  mark_rd,
  output logic        issue_stall,
  output logic        illegal,
  output logic        iss_valid,
  output fp_op_e      iss_op,
  output logic [4:0]  iss_rd,
  output logic [31:0] iss_a,
  output logic [31:0] iss_b
);

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;
  fp_op_e     op;
  logic       legal;
  logic       use_rs1;   // fp source regs
  logic       use_rs2;
  logic       fp_rd;     // fp destination
  logic       issue;

  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign funct7   = instr[31:25];
  assign rd_addr  = instr[11:7];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];

  always_comb begin
    op    = FSGNJ;
    legal = 1'b0;
    if (opcode == `FPU_OPC_OPFP) begin
      case (funct7)
        `FPU_F7_SGNJ: begin
          legal = (funct3 <= 3'd2);
          op    = (funct3 == 3'd1) ? FSGNJN : (funct3 == 3'd2) ? FSGNJX : FSGNJ;
        end
        `FPU_F7_MINMAX: begin
          legal = (funct3 <= 3'd1);
          op    = funct3[0] ? FMAX : FMIN;
        end
        `FPU_F7_CMP: begin   // 2 feq, 1 flt, 0 fle
          legal = (funct3 <= 3'd2);
          op    = (funct3 == 3'd2) ? FEQ : (funct3 == 3'd1) ? FLT : FLE;
        end
        `FPU_F7_MVXW: begin  // funct3 1 would be fclass, not supported
          legal = (funct3 == 3'd0) && (rs2_addr == 5'd0);
          op    = MVXW;
        end
        `FPU_F7_MVWX: begin
          legal = (funct3 == 3'd0) && (rs2_addr == 5'd0);
          op    = MVWX;
        end
        default: ;
      endcase
    end
  end

  assign use_rs1 = (op != MVWX);
  assign use_rs2 = (op inside {FSGNJ, FSGNJN, FSGNJX, FMIN, FMAX, FEQ, FLT, FLE});
  assign fp_rd   = (op inside {FSGNJ, FSGNJN, FSGNJX, FMIN, FMAX, MVWX});

  // illegal words never stall, they just drain
  assign issue_stall = instr_valid && legal &&
                       ((use_rs1 && rs1_busy) || (use_rs2 && rs2_busy) || (fp_rd && rd_busy));
  assign issue       = instr_valid && !issue_stall;

  assign mark_en = issue && legal && fp_rd;
  assign mark_rd = rd_addr;

  always_ff @(posedge frf_rf or negedge rst_n) begin
    if (!rst_n) begin
      iss_valid <= 1'b0;
      illegal   <= 1'b0;
    end else begin
      iss_valid <= issue && legal;
      illegal   <= issue && !legal;   // one cycle pulse
    end
  end

  // issue payload, only loaded on a real issue
  always_ff @(posedge frf_rf) begin
    if (issue && legal) begin
      iss_op <= op;
      iss_rd <= rd_addr;
      iss_a  <= (op == MVWX) ? int_operand : rs1_data;
      iss_b  <= rs2_data;
    end
  end

  // a stalled word waits unchanged for its issue edge
  a_hold_on_stall : assert property (@(posedge frf_rf) disable iff (!rst_n)
    issue_stall |=> instr_valid && $stable(instr) && $stable(int_operand))
    else $error("instruction dropped or changed while issue was stalled");

endmodule

// File: rtl/fpu_execute.sv
// --------------------------------------------------
// fpu execute
// stage 1 classifies operands and orders magnitudes,
// stage 2 selects sgnj / minmax / compare / move
// --------------------------------------------------
`include "fpu_cfg.svh"

module fpu_execute import fpu_pkg::*; (
  input  logic        frf_rf,
  input  logic        rst_n,
  input  logic        iss_valid,
  input  fp_op_e      iss_op,
  input  logic [4:0]  iss_rd,
  input  logic [31:0] iss_a,
  input  logic [31:0] iss_b,
  output logic        ex_valid,
  output logic        ex_op_fp,   // result goes to fp reg file
  output logic [4:0]  ex_rd,
  output logic [31:0] ex_data,
  output logic        ex_nv
);

  fp32_word_u a_w, b_w;
  logic       a_nan, a_snan, a_zero;
  logic       b_nan, b_snan, b_zero;
  logic       mag_lt, mag_eq;            // |a| vs |b|
  logic       s1_valid;
  fp_op_e     s1_op;
  logic [4:0] s1_rd;
  fp32_word_u s1_a, s1_b;
  logic       s1_a_nan, s1_a_snan, s1_a_zero;
  logic       s1_b_nan, s1_b_snan, s1_b_zero;
  logic       s1_mag_lt, s1_mag_eq;
  logic       any_nan, any_snan, both_zero;
  logic       ord_lt;                    // a < b, with -0 < +0
  logic       feq, flt, fle;

  // {nan, snan, zero}
  function automatic logic [2:0] classify(input fp32_word_u w);
    logic nan;
    nan = (w.fields.exponent == 8'hff) && (w.fields.mantissa != '0);
    return {nan, nan && !w.fields.mantissa[22],
            (w.fields.exponent == 8'h00) && (w.fields.mantissa == '0)};
  endfunction

  assign a_w = iss_a;
  assign b_w = iss_b;
  assign {a_nan, a_snan, a_zero} = classify(a_w);
  assign {b_nan, b_snan, b_zero} = classify(b_w);
  // exponent:mantissa orders like an unsigned int
  assign mag_lt = {a_w.fields.exponent, a_w.fields.mantissa} <
                  {b_w.fields.exponent, b_w.fields.mantissa};
  assign mag_eq = {a_w.fields.exponent, a_w.fields.mantissa} ==
                  {b_w.fields.exponent, b_w.fields.mantissa};

  always_ff @(posedge frf_rf or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= iss_valid;
    end
  end

  always_ff @(posedge frf_rf) begin
    if (iss_valid) begin
      s1_op     <= iss_op;
      s1_rd     <= iss_rd;
      s1_a      <= a_w;
      s1_b      <= b_w;
      s1_a_nan  <= a_nan;
      s1_a_snan <= a_snan;
      s1_a_zero <= a_zero;
      s1_b_nan  <= b_nan;
      s1_b_snan <= b_snan;
      s1_b_zero <= b_zero;
      s1_mag_lt <= mag_lt;
      s1_mag_eq <= mag_eq;
    end
  end

  assign any_nan   = s1_a_nan || s1_b_nan;
  assign any_snan  = s1_a_snan || s1_b_snan;
  assign both_zero = s1_a_zero && s1_b_zero;

  always_comb begin
    if (s1_a.fields.sign != s1_b.fields.sign)
      ord_lt = s1_a.fields.sign;             // negative below positive, -0 too
    else if (s1_a.fields.sign)
      ord_lt = !s1_mag_lt && !s1_mag_eq;     // both negative, bigger mag is lower
    else
      ord_lt = s1_mag_lt;
  end

  // compares, nan always false, +0 == -0
  assign feq = !any_nan && ((s1_mag_eq && (s1_a.fields.sign == s1_b.fields.sign)) || both_zero);
  assign flt = !any_nan && ord_lt && !both_zero;
  assign fle = !any_nan && (ord_lt || feq);

  always_comb begin
    ex_data = s1_a.bits;   // moves pass a through untouched
    ex_nv   = 1'b0;
    case (s1_op)
      FSGNJ:  ex_data = {s1_b.fields.sign, s1_a.bits[30:0]};
      FSGNJN: ex_data = {~s1_b.fields.sign, s1_a.bits[30:0]};
      FSGNJX: ex_data = {s1_a.fields.sign ^ s1_b.fields.sign, s1_a.bits[30:0]};
      FMIN, FMAX: begin
        if (s1_a_nan && s1_b_nan) ex_data = `FPU_CANON_NAN;
        else if (s1_a_nan) ex_data = s1_b.bits;   // single nan loses
        else if (s1_b_nan) ex_data = s1_a.bits;
        else if (ord_lt == (s1_op == FMIN)) ex_data = s1_a.bits;
        else ex_data = s1_b.bits;
        ex_nv = any_snan;   // qnan is quiet here
      end
      FEQ: begin
        ex_data = {31'd0, feq};
        ex_nv   = any_snan;
      end
      FLT: begin
        ex_data = {31'd0, flt};
        ex_nv   = any_nan;   // signaling compare
      end
      FLE: begin
        ex_data = {31'd0, fle};
        ex_nv   = any_nan;
      end
      default: ;
    endcase
  end

  assign ex_valid = s1_valid;
  assign ex_rd    = s1_rd;
  assign ex_op_fp = (s1_op inside {FSGNJ, FSGNJN, FSGNJX, FMIN, FMAX, MVWX});

  a_known_op : assert property (@(posedge frf_rf) disable iff (!rst_n)
    iss_valid |-> !$isunknown(iss_op))
    else $error("unknown op on issue bus");

endmodule

// File: rtl/fpu_result.sv
// --------------------------------------------------
// fpu result stage
// registers execute output, writes fp regs or
// returns int result, keeps sticky nv flag
// --------------------------------------------------
module fpu_result (
  input  logic        frf_rf,
  input  logic        rst_n,
  input  logic        ex_valid,
  input  logic        ex_op_fp,
  input  logic [4:0]  ex_rd,
  input  logic [31:0] ex_data,
  input  logic        ex_nv,
  input  logic        clear_flags,
  output logic        wen,
  output logic [4:0]  wrd,
  output logic [31:0] wdata,
  output logic        fp_wb_valid,
  output logic [4:0]  fp_wb_rd,
  output logic [31:0] fp_wb_data,
  output logic        int_valid,
  output logic [4:0]  int_rd,
  output logic [31:0] int_data,
  output logic        fflags_nv
);

  logic [4:0]  res_rd;     // shared by both destinations
  logic [31:0] res_data;

  always_ff @(posedge frf_rf or negedge rst_n) begin
    if (!rst_n) begin
      fp_wb_valid <= 1'b0;
      int_valid   <= 1'b0;
      fflags_nv   <= 1'b0;
    end else begin
      fp_wb_valid <= ex_valid && ex_op_fp;
      int_valid   <= ex_valid && !ex_op_fp;
      if (clear_flags)
        fflags_nv <= 1'b0;   // clear beats a new set
      else if (ex_valid && ex_nv)
        fflags_nv <= 1'b1;
    end
  end

  always_ff @(posedge frf_rf) begin
    if (ex_valid) begin
      res_rd   <= ex_rd;
      res_data <= ex_data;
    end
  end

  // fp results go to the reg file and out at the same time
  assign wen        = fp_wb_valid;
  assign wrd        = res_rd;
  assign wdata      = res_data;
  assign fp_wb_rd   = res_rd;
  assign fp_wb_data = res_data;
  assign int_rd     = res_rd;   // x reg index for fmv.x.w / compares
  assign int_data   = res_data;

endmodule

// File: rtl/fpu_top.sv
// --------------------------------------------------
// fpu top
// decode, fp register file, execute and result
// --------------------------------------------------
module fpu_top import fpu_pkg::*; (
  input  logic        frf_rf,
  input  logic        rst_n,
  input  logic        instr_valid,
  input  logic [31:0] instr,
  input  logic [31:0] int_operand,
  input  logic        clear_flags,
  output logic        issue_stall,
  output logic        illegal,
  output logic        fp_wb_valid,
  output logic [4:0]  fp_wb_rd,
  output logic [31:0] fp_wb_data,
  output logic        int_valid,
  output logic [4:0]  int_rd,
  output logic [31:0] int_data,
  output logic        fflags_nv
);

  logic [4:0]  rs1_addr, rs2_addr, rd_addr;
  logic [31:0] rs1_data, rs2_data;
  logic        rs1_busy, rs2_busy, rd_busy;
  logic        mark_en;
  logic [4:0]  mark_rd;
  logic        iss_valid;
  fp_op_e      iss_op;
  logic [4:0]  iss_rd;
  logic [31:0] iss_a, iss_b;
  logic        ex_valid, ex_op_fp, ex_nv;
  logic [4:0]  ex_rd;
  logic [31:0] ex_data;
  logic        wen;
  logic [4:0]  wrd;
  logic [31:0] wdata;

  fpu_decode u_decode (
    .frf_rf, .rst_n, .instr_valid, .instr, .int_operand,
    .rs1_data, .rs2_data, .rs1_busy, .rs2_busy, .rd_busy,
    .rs1_addr, .rs2_addr, .rd_addr, .mark_en, .mark_rd,
    .issue_stall, .illegal,
    .iss_valid, .iss_op, .iss_rd, .iss_a, .iss_b
  );

  fpu_reg_file u_reg_file (
    .frf_rf, .rst_n, .rs1_addr, .rs2_addr, .rd_addr,
    .mark_en, .mark_rd, .wen, .wrd, .wdata,
    .rs1_data, .rs2_data, .rs1_busy, .rs2_busy, .rd_busy
  );

  fpu_execute u_execute (
    .frf_rf, .rst_n, .iss_valid, .iss_op, .iss_rd, .iss_a, .iss_b,
    .ex_valid, .ex_op_fp, .ex_rd, .ex_data, .ex_nv
  );

  fpu_result u_result (
    .frf_rf, .rst_n, .ex_valid, .ex_op_fp, .ex_rd, .ex_data, .ex_nv, .clear_flags,
    .wen, .wrd, .wdata,
    .fp_wb_valid, .fp_wb_rd, .fp_wb_data,
    .int_valid, .int_rd, .int_data, .fflags_nv
  );

endmodule

// File: bench/fpu_tb.sv
// ----------------------------------------------
// fpu testbench
// directed and random op-fp words, checked against
// a reference model of the fp regs and the nv flag
// ----------------------------------------------
`include "fpu_cfg.svh"

module fpu_tb import fpu_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD  = 8;
  localparam int N_INSTR     = 32 + 32 + 512 + 768 + 48 + 400;   // sum over test groups
  localparam int CYCLE_LIMIT = 20 * N_INSTR + 100;

  typedef struct packed {
    logic        legal;
    logic        fp_dest;   // else int side
    logic [4:0]  rd;
    logic [31:0] data;
    logic        nv;
    logic [63:0] t_issue;   // ns
  } expect_t;

  logic        frf_rf, rst_n;
  logic        instr_valid, clear_flags;
  logic [31:0] instr, int_operand;
  logic        issue_stall, illegal;
  logic        fp_wb_valid, int_valid, fflags_nv;
  logic [4:0]  fp_wb_rd, int_rd;
  logic [31:0] fp_wb_data, int_data;

  logic [31:0] model_regs [`FPU_NUM_REGS];
  logic        model_nv = 1'b0;
  logic        illegal_exp = 1'b0;   // illegal pulse due at next edge
  expect_t     exp_q [$];
  int          cycles = 0;
  integer      seed;

  // +0 -0 +inf -inf qnan snan -qnan 1 -1 2.5 -3.75 +denorm -denorm maxnorm -snan 1+ulp
  logic [31:0] special [16] = '{
    32'h00000000, 32'h80000000, 32'h7f800000, 32'hff800000,
    32'h7fc00000, 32'h7f800001, 32'hffc00001, 32'h3f800000,
    32'hbf800000, 32'h40200000, 32'hc0700000, 32'h00000001,
    32'h80000001, 32'h7f7fffff, 32'hffa00000, 32'h3f800001};
  fp_op_e all_ops [10] = '{FSGNJ, FSGNJN, FSGNJX, FMIN, FMAX, FEQ, FLT, FLE, MVXW, MVWX};

  fpu_top UUT (.*);

  initial begin
    frf_rf = 1'b0;
    forever #(CLK_PERIOD / 2) frf_rf = ~frf_rf;
  end

  function automatic logic is_nan(input logic [31:0] w);
    return (w[30:23] == 8'hff) && (w[22:0] != 23'd0);
  endfunction

  function automatic logic is_snan(input logic [31:0] w);
    return is_nan(w) && !w[22];   // quiet bit clear
  endfunction

  function automatic logic is_zero(input logic [31:0] w);
    return w[30:0] == 31'd0;
  endfunction

  // unsigned key with float order, -0 just below +0
  function automatic logic [31:0] order_key(input logic [31:0] w);
    return w[31] ? ~w : {1'b1, w[30:0]};
  endfunction

  function automatic expect_t fpu_ref(input logic [31:0] word, input logic [31:0] iop);
    expect_t     e;
    logic [31:0] a, b;
    logic [2:0]  f3;
    logic        unord, same, lt;
    e     = '0;
    f3    = word[14:12];
    a     = model_regs[word[19:15]];
    b     = model_regs[word[24:20]];
    unord = is_nan(a) || is_nan(b);
    same  = (a == b) || (is_zero(a) && is_zero(b));   // +0 == -0
    lt    = order_key(a) < order_key(b);
    e.rd  = word[11:7];
    if (word[6:0] == `FPU_OPC_OPFP) begin
      case (word[31:25])
        `FPU_F7_SGNJ: begin
          e.legal   = (f3 <= 3'd2);
          e.fp_dest = 1'b1;
          e.data    = {(f3 == 3'd0) ? b[31] : (f3 == 3'd1) ? !b[31] : a[31] ^ b[31], a[30:0]};
        end
        `FPU_F7_MINMAX: begin
          e.legal   = (f3 <= 3'd1);
          e.fp_dest = 1'b1;
          e.nv      = is_snan(a) || is_snan(b);   // quiet nans stay silent
          if (is_nan(a) && is_nan(b))
            e.data = `FPU_CANON_NAN;
          else if (unord)
            e.data = is_nan(a) ? b : a;   // number beats nan
          else
            e.data = f3[0] ? (lt ? b : a) : (lt ? a : b);
        end
        `FPU_F7_CMP: begin
          e.legal = (f3 <= 3'd2);
          case (f3)
            3'd2:    e.data = {31'd0, !unord && same};
            3'd1:    e.data = {31'd0, !unord && !same && lt};
            default: e.data = {31'd0, !unord && (same || lt)};
          endcase
          e.nv = (f3 == 3'd2) ? (is_snan(a) || is_snan(b)) : unord;   // flt/fle signal on qnan
        end
        `FPU_F7_MVXW: begin
          e.legal = (f3 == 3'd0) && (word[24:20] == 5'd0);
          e.data  = a;
        end
        `FPU_F7_MVWX: begin
          e.legal   = (f3 == 3'd0) && (word[24:20] == 5'd0);
          e.fp_dest = 1'b1;
          e.data    = iop;
        end
        default: ;
      endcase
    end
    return e;
  endfunction

  // legal word touching a reg whose fp result is still in flight
  function automatic logic must_wait(input logic [31:0] word);
    expect_t    e;
    logic [6:0] f7;
    logic       hit;
    e   = fpu_ref(word, 32'd0);
    f7  = word[31:25];
    hit = 1'b0;
    foreach (exp_q[n]) begin
      if (exp_q[n].fp_dest) begin
        // fmv.w.x reads no fp reg, fmv.x.w only rs1
        hit = hit || (f7 != `FPU_F7_MVWX && exp_q[n].rd == word[19:15]) ||
              (f7 != `FPU_F7_MVWX && f7 != `FPU_F7_MVXW && exp_q[n].rd == word[24:20]) ||
              (e.fp_dest && exp_q[n].rd == word[11:7]);
      end
    end
    return e.legal && hit;
  endfunction

  function automatic logic [31:0] encode(input fp_op_e op, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [4:0] rs2);
    logic [9:0] f;   // funct7, funct3
    logic [4:0] src2;
    src2 = rs2;
    case (op)
      FSGNJ:   f = {`FPU_F7_SGNJ, 3'd0};
      FSGNJN:  f = {`FPU_F7_SGNJ, 3'd1};
      FSGNJX:  f = {`FPU_F7_SGNJ, 3'd2};
      FMIN:    f = {`FPU_F7_MINMAX, 3'd0};
      FMAX:    f = {`FPU_F7_MINMAX, 3'd1};
      FEQ:     f = {`FPU_F7_CMP, 3'd2};
      FLT:     f = {`FPU_F7_CMP, 3'd1};
      FLE:     f = {`FPU_F7_CMP, 3'd0};
      MVXW:    f = {`FPU_F7_MVXW, 3'd0};
      default: f = {`FPU_F7_MVWX, 3'd0};
    endcase
    if (op inside {MVXW, MVWX})
      src2 = 5'd0;   // moves carry a zero rs2 field
    return {f[9:3], src2, rs1, f[2:0], rd, `FPU_OPC_OPFP};
  endfunction

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // call right after an edge, returns at the edge the word is consumed
  task automatic send(input logic [31:0] word, input logic [31:0] iop);
    instr_valid <= 1'b1;
    instr       <= word;
    int_operand <= iop;
    @(posedge frf_rf);
    while (issue_stall)
      @(posedge frf_rf);
  endtask

  // last result is due 3 cycles after the final issue
  task automatic drain();
    int n;
    n = 0;
    instr_valid <= 1'b0;
    @(posedge frf_rf);
    while ((exp_q.size() != 0 || illegal_exp) && n < 4) begin
      @(posedge frf_rf);
      n++;
    end
    @(posedge frf_rf);
  endtask

  task automatic clear_nv();
    drain();   // nothing in flight while clearing
    clear_flags <= 1'b1;
    @(posedge frf_rf);
    clear_flags <= 1'b0;
    model_nv = 1'b0;
    @(posedge frf_rf);
    assert (fflags_nv == 1'b0)
      else fail_now($sformatf("Error: fflags_nv = %h after clear, expected 0", fflags_nv));
  endtask

  always @(posedge frf_rf) begin : watchdog
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT)
      fail_now($sformatf("timeout after %0d cycles waiting on the DUT", cycles));
  end

  always @(posedge frf_rf) begin : issue_monitor
    expect_t e;
    if (rst_n) begin
      assert (illegal == illegal_exp)
        else fail_now($sformatf("Error: illegal = %h, expected %h", illegal, illegal_exp));
      illegal_exp = 1'b0;
      if (instr_valid && !issue_stall) begin
        e         = fpu_ref(instr, int_operand);
        e.t_issue = $time;
        if (e.legal)
          exp_q.push_back(e);
        else
          illegal_exp = 1'b1;   // no result, just the pulse
      end
    end
  end

  // mid cycle, scoreboard and inputs have settled
  always @(negedge frf_rf) begin : stall_check
    logic stall_exp;
    if (rst_n) begin
      stall_exp = instr_valid && must_wait(instr);
      assert (issue_stall == stall_exp)
        else fail_now($sformatf("Error: issue_stall = %h, expected %h", issue_stall, stall_exp));
    end
  end

  always @(posedge frf_rf) begin : result_compare
    expect_t e;
    if (rst_n && (fp_wb_valid || int_valid)) begin
      assert (exp_q.size() != 0)
        else fail_now("a result pulse arrived with no instruction outstanding");
      e = exp_q.pop_front();
      assert (fp_wb_valid == e.fp_dest && int_valid == !e.fp_dest)
        else fail_now($sformatf("Error: fp_wb_valid/int_valid = %h/%h, expected %h/%h",
                                fp_wb_valid, int_valid, e.fp_dest, !e.fp_dest));
      assert (($time - e.t_issue) == 64'(3 * CLK_PERIOD))
        else fail_now($sformatf("result for rd %0d came %0d ns after issue, not 3 cycles",
                                e.rd, $time - e.t_issue));
      if (e.fp_dest) begin
        assert (fp_wb_rd == e.rd)
          else fail_now($sformatf("Error: fp_wb_rd = %h, expected %h", fp_wb_rd, e.rd));
        assert (fp_wb_data == e.data)
          else fail_now($sformatf("Error: fp_wb_data = %h, expected %h", fp_wb_data, e.data));
        model_regs[e.rd] = e.data;   // write completes now
      end else begin
        assert (int_rd == e.rd)
          else fail_now($sformatf("Error: int_rd = %h, expected %h", int_rd, e.rd));
        assert (int_data == e.data)
          else fail_now($sformatf("Error: int_data = %h, expected %h", int_data, e.data));
      end
      model_nv = model_nv | e.nv;   // sticky
      assert (fflags_nv == model_nv)
        else fail_now($sformatf("Error: fflags_nv = %h, expected %h", fflags_nv, model_nv));
    end
  end

  initial begin : stimulus
    logic [31:0] r;
    logic [31:0] word;
    int          k;
    seed        = 32'h2b32;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    int_operand = '0;
    clear_flags = 1'b0;
    for (int i = 0; i < `FPU_NUM_REGS; i++)
      model_regs[i] = `FPU_CANON_NAN;
    repeat (2) @(posedge frf_rf);
    rst_n <= 1'b1;
    @(posedge frf_rf);
    assert (!fp_wb_valid && !int_valid && !illegal && !fflags_nv)
      else fail_now($sformatf(
        "Error: fp_wb_valid/int_valid/illegal/fflags_nv = %h/%h/%h/%h, expected 0",
        fp_wb_valid, int_valid, illegal, fflags_nv));
    // every reg reads back as canonical nan
    for (int i = 0; i < 32; i++)
      send(encode(MVXW, 5'(i), 5'(i), 5'd0), 32'd0);
    // load specials into f0..f15, sign injection into f16..f31
    for (int i = 0; i < 16; i++)
      send(encode(MVWX, 5'(i), 5'd0, 5'd0), special[i]);
    for (int i = 0; i < 16; i++)
      send(encode(all_ops[i % 3], 5'(16 + i), 5'(i), 5'((i * 5 + 3) % 16)), 32'd0);
    clear_nv();
    k = 0;
    for (int i = 0; i < 16; i++) begin   // min/max over all special pairs
      for (int j = 0; j < 16; j++) begin
        for (int m = 3; m < 5; m++) begin
          send(encode(all_ops[m], 5'(16 + k % 16), 5'(i), 5'(j)), 32'd0);
          k++;
        end
      end
    end
    clear_nv();
    for (int i = 0; i < 16; i++) begin   // feq/flt/fle, int rd
      for (int j = 0; j < 16; j++) begin
        for (int m = 5; m < 8; m++) begin
          send(encode(all_ops[m], 5'(k % 32), 5'(i), 5'(j)), 32'd0);
          k++;
        end
      end
    end
    clear_nv();
    // dependent chain, each op reads the previous rd
    for (k = 0; k < 48; k++) begin
      if (k % 6 == 5)
        send(encode(MVXW, 5'(k), 5'(16 + (k + 3) % 4), 5'd0), 32'd0);
      else
        send(encode(all_ops[k % 5], 5'(16 + k % 4), 5'(16 + (k + 3) % 4), 5'(k % 16)), 32'd0);
    end
    // random mix with illegal words
    for (k = 0; k < 400; k++) begin
      r = $random(seed);
      case (r[2:0])
        3'd0:    word = $random(seed);   // almost never op-fp
        3'd1:    word = {r[18] ? 7'b0001000 : `FPU_F7_SGNJ, r[17:8], 3'd7, r[7:3], `FPU_OPC_OPFP};
        3'd2:    word = encode(MVWX, r[7:3], r[12:8], 5'd0);
        default: word = encode(all_ops[int'(r[21:18]) % 10], r[7:3], r[12:8], r[17:13]);
      endcase
      send(word, r[22] ? special[r[26:23]] : $random(seed));
    end
    drain();
    if (exp_q.size() != 0)
      fail_now("instructions were issued but never returned a result");
    else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

// File: compile.f
+incdir+rtl
rtl/fpu_pkg.sv
rtl/fpu_reg_file.sv
rtl/fpu_decode.sv
rtl/fpu_execute.sv
rtl/fpu_result.sv
rtl/fpu_top.sv
bench/fpu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the fpu testbench with verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module fpu_tb -o fpu_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/fpu_sim > sim.log 2>&1
sim_status=$?

if grep -q -F "*** TEST FAILED ***" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulator exited with status $sim_status, see sim.log"
  exit 1
fi
if ! grep -q -F "*** TEST PASSED ***" sim.log; then
  echo "no pass message in sim.log"
  exit 1
fi
echo "simulation passed"
exit 0
